/* compile.f */
+incdir+rtl
+incdir+dv
rtl/cart_pkg.sv
rtl/cart_header.sv
rtl/mbc_regs.sv
rtl/mbc_map.sv
rtl/cart_ram.sv
rtl/cart_bus_ctrl.sv
rtl/cart_mapper_top.sv
dv/tb_cart_mapper.sv

/* dv/cart_model.svh */
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// ------------------------------
// reference state of the cart
// ------------------------------
mbc_kind_e  m_kind;
logic [8:0] m_rom_mask;
logic [3:0] m_ram_mask;
logic [8:0] m_rom_bank;
logic [3:0] m_ram_bank;
logic       m_mode, m_rtc, m_ram_en;
logic [7:0] m_ram [int];             // only bytes written so far

function automatic void decode_header(input logic [7:0] t, input logic [7:0] rs,
		input logic [7:0] ms);
	int masks;
	if (t >= 8'h01 && t <= 8'h03)      m_kind = MBC_1;
	else if (t == 8'h05 || t == 8'h06) m_kind = MBC_2;
	else if (t >= 8'h0F && t <= 8'h13) m_kind = MBC_3;
	else if (t >= 8'h19 && t <= 8'h1E) m_kind = MBC_5;
	else                               m_kind = MBC_NONE;
	masks = (2 << rs) - 1;            // banks minus one
	m_rom_mask = (rs <= 8'd8) ? masks[8:0] : 9'h07F;
	m_ram_mask = (ms == 8'd3) ? 4'h3 : ((ms >= 8'd4) ? 4'hF : 4'h0);
endfunction

function automatic void reset_regs();
	m_rom_bank = 9'd1;
	m_ram_bank = 4'd0;
	m_mode     = 1'b0;
	m_rtc      = 1'b0;
	m_ram_en   = 1'b0;
endfunction

function automatic void apply_reg_write(input logic [15:0] a, input logic [7:0] d);
	case (a[14:13])
		2'd0: m_ram_en = (d[3:0] == 4'hA);
		2'd1: begin
			if (m_kind == MBC_5) begin
				if (a[12]) m_rom_bank[8] = d[0];
				else       m_rom_bank[7:0] = d;
			end else begin
				m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
			end
		end
		2'd2: begin
			if (m_kind == MBC_3 && d[3]) m_rtc = 1'b1;
			else if (m_kind == MBC_5)    m_ram_bank = d[3:0];
			else begin
				m_ram_bank = {2'b00, d[1:0]};
				if (m_kind == MBC_3) m_rtc = 1'b0;
			end
		end
		default: if (m_kind == MBC_1) m_mode = d[0];
	endcase
endfunction

function automatic logic [22:0] map_rom_addr(input logic [15:0] a);
	logic [8:0] bank;
	if (a < 16'h4000) bank = 9'd0;
	else case (m_kind)
		MBC_1:        bank = {2'b00, (m_mode ? 2'b00 : m_ram_bank[1:0]), m_rom_bank[4:0]};
		MBC_2, MBC_3: bank = {2'b00, m_rom_bank[6:0]};
		MBC_5:        bank = m_rom_bank;
		default:      bank = {8'd0, a[14]};
	endcase
	if (a >= 16'h4000 && m_kind != MBC_NONE) bank = bank & m_rom_mask;
	return {bank, a[13:0]};
endfunction

function automatic logic [16:0] map_ram_addr(input logic [15:0] a);
	logic [3:0] bank;
	case (m_kind)
		MBC_1:   bank = m_mode ? (m_ram_bank & m_ram_mask & 4'h3) : 4'h0;
		MBC_3:   bank = m_ram_bank & m_ram_mask & 4'h3;
		MBC_5:   bank = m_ram_bank & m_ram_mask;
		default: bank = 4'h0;
	endcase
	return {bank, a[12:0]};
endfunction

// rom image pattern, both ends of the address show up in the byte
function automatic logic [7:0] rom_byte(input logic [22:0] a);
	return a[7:0] ^ a[22:15];
endfunction

function automatic logic ram_needs_fill(input logic [15:0] a);
	return m_ram_en && !m_rtc && !m_ram.exists(map_ram_addr(a));
endfunction

function automatic void store_ram_write(input logic [15:0] a, input logic [7:0] d);
	if (m_ram_en && !m_rtc) m_ram[map_ram_addr(a)] = d;
endfunction

function automatic logic [7:0] expected_ram_read(input logic [15:0] a);
	if (!m_ram_en) return 8'hFF;
	if (m_kind == MBC_2 && a[15:9] == 7'b1010000) return {4'hF, m_ram[map_ram_addr(a)][3:0]};
	if (m_rtc) return 8'h00;
	return m_ram[map_ram_addr(a)];
endfunction

`endif

/* dv/tb_cart_mapper.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module tb_cart_mapper import cart_pkg::*; ();

	localparam int NUM_CARTS      = 10;
	localparam int OPS_PER_CART   = 60;
	localparam int TIMEOUT_CYCLES = NUM_CARTS * OPS_PER_CART * 30 + 2000;  // ~30 cycles per op

	logic clk_sys = 1'b0, reset;
	logic dl_active_i, dl_valid_i, bus_valid_i, bus_write_i, rom_ready_i, rom_rvalid_i;
	logic [22:0] dl_addr_i;
	logic [7:0]  dl_data_i, bus_wdata_i, rom_rdata_i, bus_rdata_o;
	logic [15:0] bus_addr_i;
	logic        bus_ready_o, bus_rvalid_o, rom_valid_o;
	logic [22:0] rom_addr_o;

	integer      seed = 32'h5f6a_11bd;
	int          cycles = 0, data_errs = 0, proto_errs = 0;
	logic        rom_take = 1'b0, pend = 1'b0, held = 1'b0;
	logic [22:0] take_addr, pend_addr, held_addr;
	int          pend_dly;
	logic [31:0] rr;
	logic [31:0] rsp_r = '0;             // responder draws, taken at the falling edge

	`include "cart_model.svh"

	cart_mapper_top u_dut (.clk_sys, .reset, .dl_active_i, .dl_valid_i, .dl_addr_i, .dl_data_i,
		.bus_valid_i, .bus_ready_o, .bus_write_i, .bus_addr_i, .bus_wdata_i, .bus_rdata_o,
		.bus_rvalid_o, .rom_valid_o, .rom_ready_i, .rom_addr_o, .rom_rvalid_i, .rom_rdata_i);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d data, %0d protocol, 1 timeout", data_errs, proto_errs);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------
	// rom responder
	// ------------------------------
	always @(negedge clk_sys) begin
		rom_take  = rom_valid_o && rom_ready_i;       // handshake on the coming edge
		take_addr = rom_addr_o;
		rsp_r     = $random(seed);
		if (!reset && rom_valid_o) begin
			if (bus_ready_o) begin
				$display("FAIL %0t: bus_ready_o high while a rom request is pending", $time);
				proto_errs++;
			end
			if (held && rom_addr_o !== held_addr) begin
				$display("FAIL %0t: rom_addr_o moved under back-pressure", $time);
				proto_errs++;
			end
		end
		held      = rom_valid_o && !rom_ready_i;
		held_addr = rom_addr_o;
	end

	always @(posedge clk_sys) begin
		#1;
		rom_rvalid_i = 1'b0;
		if (rom_take) begin
			pend      = 1'b1;
			pend_addr = take_addr;
			pend_dly  = 1 + rsp_r[1:0];                // 1..4 cycles
		end else if (pend) begin
			pend_dly--;
			if (pend_dly == 0) begin
				rom_rvalid_i = 1'b1;
				rom_rdata_i  = rom_byte(pend_addr);
				pend         = 1'b0;
			end
		end
		rom_ready_i = (rsp_r[3:2] != 2'b00);          // ready 3 cycles in 4
	end

	// ------------------------------
	// bus tasks
	// ------------------------------
	task automatic wait_accept();
		logic acc;
		do begin
			@(negedge clk_sys);
			acc = bus_ready_o;                          // ready does not look at valid
			@(posedge clk_sys);
		end while (!acc);
		#1 bus_valid_i = 1'b0;
		bus_addr_i  = ~bus_addr_i;                      // request taken, payload is free again
		bus_wdata_i = ~bus_wdata_i;
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		bus_valid_i = 1'b1;
		bus_write_i = 1'b1;
		bus_addr_i  = a;
		bus_wdata_i = d;
		wait_accept();
		if (!a[15])                  apply_reg_write(a, d);
		else if (a[15:13] == 3'b101) store_ram_write(a, d);
	endtask

	task automatic bus_read(input logic [15:0] a, input logic [7:0] exp);
		int   lat;
		logic rv_prev;                                  // rom data seen in the cycle before
		bus_valid_i = 1'b1;
		bus_write_i = 1'b0;
		bus_addr_i  = a;
		wait_accept();
		lat     = 0;
		rv_prev = 1'b0;
		do begin
			@(negedge clk_sys);
			lat++;
			if (lat == 1 && !a[15] && !rom_valid_o) begin
				$display("FAIL %0t: rom_valid_o not raised one cycle after read of %h",
					$time, a);
				proto_errs++;
			end
			if (bus_rvalid_o && !a[15] && !rv_prev) begin
				$display("FAIL %0t: read %h answered without rom data the cycle before",
					$time, a);
				proto_errs++;
			end
			rv_prev = rom_rvalid_i;
		end while (!bus_rvalid_o);
		if (a[15] && lat != 2) begin
			$display("FAIL %0t: read %h answered after %0d cycles, not 2", $time, a, lat);
			proto_errs++;
		end
		if (bus_rdata_o !== exp) begin
			$display("FAIL %0t: read %h got %h exp %h", $time, a, bus_rdata_o, exp);
			data_errs++;
		end
		@(posedge clk_sys);
		#1;
	endtask

	task automatic rom_read(input logic [15:0] a);
		logic [22:0] exp_addr;
		exp_addr = map_rom_addr(a);
		bus_read(a, rom_byte(exp_addr));
		// the data pattern misses some address bits, so the fetch address is checked too
		if (pend_addr !== exp_addr) begin
			$display("FAIL %0t: read %h fetched rom %h exp %h", $time, a, pend_addr, exp_addr);
			data_errs++;
		end
	endtask

	task automatic ram_read(input logic [15:0] a, input logic [7:0] fill);
		if (ram_needs_fill(a)) bus_write(a, fill);   // never read a byte that was not written
		bus_read(a, expected_ram_read(a));
	endtask

	task automatic download(input logic [7:0] t, input logic [7:0] rs, input logic [7:0] ms);
		int i;
		dl_active_i = 1'b1;
		for (i = 'h140; i < 'h150; i++) begin
			rr = $random(seed);
			dl_valid_i = 1'b1;
			dl_addr_i  = i[22:0];
			dl_data_i  = (i == `CART_HDR_TYPE) ? t : (i == `CART_HDR_ROM_SIZE) ? rs :
				(i == `CART_HDR_RAM_SIZE) ? ms : rr[7:0];
			@(negedge clk_sys);
			if (bus_ready_o) begin
				$display("FAIL %0t: bus_ready_o high during download", $time);
				proto_errs++;
			end
			@(posedge clk_sys);
			#1;
		end
		dl_valid_i  = 1'b0;
		dl_active_i = 1'b0;
		decode_header(t, rs, ms);
		reset_regs();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [31:0] r, r2;
		logic [7:0]  t, rs, ms, d;
		logic [15:0] a;
		reset = 1'b1;
		{dl_active_i, dl_valid_i, bus_valid_i, bus_write_i} = '0;
		{rom_ready_i, rom_rvalid_i} = '0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		bus_addr_i  = '0;
		bus_wdata_i = '0;
		rom_rdata_i = '0;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;

		for (int c = 0; c < NUM_CARTS; c++) begin
			r = $random(seed);
			case (c % 5)                               // one type code per mapper kind
				0:       t = r[0] ? 8'h00 : 8'h20;
				1:       t = 8'h01 + r[7:0] % 8'd3;
				2:       t = 8'h05 + {7'd0, r[0]};
				3:       t = 8'h0F + r[7:0] % 8'd5;
				default: t = 8'h19 + r[7:0] % 8'd6;
			endcase
			rs = (r[11:8] == 4'hF) ? 8'h52 : {4'h0, r[11:8]} % 8'd9;
			ms = {4'h0, r[15:12]} % 8'd6;
			download(t, rs, ms);

			// registers back at reset values
			rom_read(16'h4000 | {2'b00, r[29:16]});
			bus_read(16'hA000 | {3'b000, r[28:16]}, 8'hFF);

			for (int op = 0; op < OPS_PER_CART; op++) begin
				r  = $random(seed);
				r2 = $random(seed);
				case (r[2:0])
					3'd0, 3'd1: rom_read({1'b0, r2[14:0]});
					3'd2: begin
						a = {1'b0, r2[14:0]};
						if (r[5:3] == 3'd0)                   d = 8'h00;   // bank 0 cases
						else if (a[14:13] == 2'd0 && r[6])    d = 8'h0A;
						else                                  d = r2[23:16];
						bus_write(a, d);
					end
					3'd3:       bus_write(16'hA000 | {3'b000, r2[12:0]}, r2[23:16]);
					3'd4, 3'd5: ram_read(16'hA000 | {3'b000, r2[12:0]}, r2[23:16]);
					3'd6: begin
						a = r[3] ? (16'h8000 | {3'b000, r2[12:0]}) : (16'hC000 | {2'b00, r2[13:0]});
						bus_read(a, 8'hFF);                          // nothing mapped there
					end
					default:    bus_write({3'b000, r2[12:0]}, 8'h0A);  // enable key
				endcase
			end
		end

		$display("errors: %0d data, %0d protocol", data_errs, proto_errs);
		if (data_errs + proto_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* rtl/cart_bus_ctrl.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module cart_bus_ctrl import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        dl_active_i,
	input  logic                        bus_valid_i,
	input  logic                        bus_write_i,
	input  logic [`CART_ADDR_W-1:0]     bus_addr_i,
	input  logic [`CART_ROM_ADDR_W-1:0] rom_addr_i,   // mapped address from mbc_map
	input  logic                        rom_ready_i,
	input  logic                        rom_rvalid_i,
	input  logic [`CART_DATA_W-1:0]     rom_rdata_i,
	input  logic [`CART_DATA_W-1:0]     ram_rdata_i,
	output logic                        bus_ready_o,
	output logic [`CART_DATA_W-1:0]     bus_rdata_o,
	output logic                        bus_rvalid_o,
	output logic                        reg_wr_en_o,
	output logic                        ram_wr_en_o,
	output logic                        rom_valid_o,
	output logic [`CART_ROM_ADDR_W-1:0] rom_addr_o
);

	bus_state_e state;
	logic       accept;
	logic       is_rom;       // 0000-7fff
	logic       is_ram;       // a000-bfff
	logic       resp_ram_q;   // ST_RESP returns ram data, else open bus

	assign is_rom = !bus_addr_i[15];
	assign is_ram = (bus_addr_i[15:13] == 3'b101);

	assign bus_ready_o = (state == ST_IDLE) && !dl_active_i;
	assign accept      = bus_valid_i && bus_ready_o;
	assign reg_wr_en_o = accept && bus_write_i && is_rom;     // writes are done here
	assign ram_wr_en_o = accept && bus_write_i && is_ram;
	assign rom_valid_o = (state == ST_ROM_REQ);

	// ------------------------------
	// sequencer
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= ST_IDLE;
			bus_rvalid_o <= 1'b0;
		end else begin
			bus_rvalid_o <= 1'b0;                          // single cycle pulse
			case (state)
				ST_IDLE: begin
					if (accept && !bus_write_i)
						state <= is_rom ? ST_ROM_REQ : ST_RESP;
				end
				ST_ROM_REQ: if (rom_ready_i) state <= ST_ROM_WAIT;
				ST_ROM_WAIT: begin
					if (rom_rvalid_i) begin
						state        <= ST_IDLE;
						bus_rvalid_o <= 1'b1;
					end
				end
				default: begin                             // ST_RESP, ram data is out now
					state        <= ST_IDLE;
					bus_rvalid_o <= 1'b1;
				end
			endcase
		end
	end

	// payload side
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_addr_o <= rom_addr_i;                      // held through back-pressure
			resp_ram_q <= is_ram;
		end
		if (state == ST_ROM_WAIT)
			bus_rdata_o <= rom_rdata_i;
		else if (state == ST_RESP)
			bus_rdata_o <= resp_ram_q ? ram_rdata_i : `CART_OPEN_BUS;  // unmapped reads float
	end

endmodule

/* rtl/cart_header.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module cart_header import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        dl_active_i,  // image load in progress
	input  logic                        dl_valid_i,
	input  logic [`CART_ROM_ADDR_W-1:0] dl_addr_i,    // byte offset into the image
	input  logic [`CART_DATA_W-1:0]     dl_data_i,
	output mbc_kind_e                   mbc_kind_o,
	output logic [`CART_ROM_BANK_W-1:0] rom_mask_o,
	output logic [`CART_RAM_BANK_W-1:0] ram_mask_o
);

	logic                    dl_active_q;   // for the start of a download
	logic [`CART_DATA_W-1:0] hdr_type_q;
	logic [`CART_DATA_W-1:0] hdr_rom_size_q;
	logic [`CART_DATA_W-1:0] hdr_ram_size_q;

	// ------------------------------
	// header capture
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q    <= 1'b0;
			hdr_type_q     <= '0;
			hdr_rom_size_q <= '0;
			hdr_ram_size_q <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			// new image, forget the old cart
			if (dl_active_i && !dl_active_q) begin
				hdr_type_q     <= '0;
				hdr_rom_size_q <= '0;
				hdr_ram_size_q <= '0;
			end
			// a beat in the same cycle still lands, it comes after the clear
			if (dl_active_i && dl_valid_i) begin
				if (dl_addr_i == `CART_HDR_TYPE)     hdr_type_q     <= dl_data_i;
				if (dl_addr_i == `CART_HDR_ROM_SIZE) hdr_rom_size_q <= dl_data_i;
				if (dl_addr_i == `CART_HDR_RAM_SIZE) hdr_ram_size_q <= dl_data_i;
			end
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	always_comb begin
		case (hdr_type_q) inside
			[8'h01:8'h03]: mbc_kind_o = MBC_1;    // plain, +ram, +ram+battery
			[8'h05:8'h06]: mbc_kind_o = MBC_2;
			[8'h0F:8'h13]: mbc_kind_o = MBC_3;    // with and without timer
			[8'h19:8'h1E]: mbc_kind_o = MBC_5;    // incl. rumble variants
			default:       mbc_kind_o = MBC_NONE;
		endcase
	end

	always_comb begin
		// 2 << c banks, code 8 wraps to all ones in 9 bits
		if (hdr_rom_size_q <= 8'd8)
			rom_mask_o = (9'd2 << hdr_rom_size_q[3:0]) - 9'd1;
		else
			rom_mask_o = 9'h07F;                  // odd sizes 0x52..0x54, 128 banks
	end

	always_comb begin
		if (hdr_ram_size_q == 8'd3)
			ram_mask_o = 4'h3;                    // 32k, 4 banks
		else if (hdr_ram_size_q >= 8'd4)
			ram_mask_o = 4'hF;                    // 128k, 16 banks
		else
			ram_mask_o = 4'h0;                    // none, 2k or a single 8k bank
	end

endmodule

/* rtl/cart_macros.svh */
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// ------------------------------
// bus and data widths
// ------------------------------
`define CART_ADDR_W         16                  // cpu address
`define CART_DATA_W         8                   // byte wide everywhere

// ------------------------------
// banking geometry
// ------------------------------
`define CART_ROM_BANK_W     9                   // up to 512 banks of 16k
`define CART_ROM_OFS_W      14                  // offset inside a 16k rom bank
`define CART_ROM_ADDR_W     23                  // bank above offset, 8 MB
`define CART_RAM_BANK_W     4                   // up to 16 banks of 8k
`define CART_RAM_OFS_W      13                  // offset inside an 8k ram bank
`define CART_RAM_ADDR_W     17                  // 128 KB of cart ram
`define CART_RAM_SIZE       (1 << `CART_RAM_ADDR_W)

// ------------------------------
// header byte offsets in the image
// ------------------------------
`define CART_HDR_TYPE       'h147               // cartridge type / mapper code
`define CART_HDR_ROM_SIZE   'h148
`define CART_HDR_RAM_SIZE   'h149

// misc constants
`define CART_RAM_ENABLE_KEY 4'hA                // low nibble that opens ram
`define CART_OPEN_BUS       8'hFF               // value of an undriven bus

`endif

/* rtl/cart_mapper_top.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module cart_mapper_top import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	// image download
	input  logic                        dl_active_i,
	input  logic                        dl_valid_i,
	input  logic [`CART_ROM_ADDR_W-1:0] dl_addr_i,
	input  logic [`CART_DATA_W-1:0]     dl_data_i,
	// cpu side
	input  logic                        bus_valid_i,
	output logic                        bus_ready_o,
	input  logic                        bus_write_i,
	input  logic [`CART_ADDR_W-1:0]     bus_addr_i,
	input  logic [`CART_DATA_W-1:0]     bus_wdata_i,
	output logic [`CART_DATA_W-1:0]     bus_rdata_o,
	output logic                        bus_rvalid_o,
	// external rom
	output logic                        rom_valid_o,
	input  logic                        rom_ready_i,
	output logic [`CART_ROM_ADDR_W-1:0] rom_addr_o,
	input  logic                        rom_rvalid_i,
	input  logic [`CART_DATA_W-1:0]     rom_rdata_i
);

	mbc_kind_e                   mbc_kind;
	logic [`CART_ROM_BANK_W-1:0] rom_mask;
	logic [`CART_RAM_BANK_W-1:0] ram_mask;
	logic [`CART_ROM_BANK_W-1:0] rom_bank;
	logic [`CART_RAM_BANK_W-1:0] ram_bank;
	logic                        mbc1_mode, rtc_mode, ram_enable;
	logic                        reg_wr_en, ram_wr_en;
	logic [`CART_ROM_ADDR_W-1:0] rom_addr;   // combinational map, latched by bus ctrl
	logic [`CART_RAM_ADDR_W-1:0] ram_addr;
	logic [`CART_DATA_W-1:0]     ram_rdata;

	cart_header u_header (.clk_sys, .reset, .dl_active_i, .dl_valid_i, .dl_addr_i, .dl_data_i,
		.mbc_kind_o(mbc_kind), .rom_mask_o(rom_mask), .ram_mask_o(ram_mask));

	mbc_regs u_regs (.clk_sys, .reset, .dl_active_i, .reg_wr_en_i(reg_wr_en), .bus_addr_i,
		.bus_wdata_i, .mbc_kind_i(mbc_kind), .rom_bank_o(rom_bank), .ram_bank_o(ram_bank),
		.mbc1_mode_o(mbc1_mode), .rtc_mode_o(rtc_mode), .ram_enable_o(ram_enable));

	mbc_map u_map (.bus_addr_i, .mbc_kind_i(mbc_kind), .rom_mask_i(rom_mask),
		.ram_mask_i(ram_mask), .rom_bank_i(rom_bank), .ram_bank_i(ram_bank),
		.mbc1_mode_i(mbc1_mode), .rom_addr_o(rom_addr), .ram_addr_o(ram_addr));

	cart_ram u_ram (.clk_sys, .ram_wr_en_i(ram_wr_en), .ram_addr_i(ram_addr), .bus_addr_i,
		.bus_wdata_i, .mbc_kind_i(mbc_kind), .ram_enable_i(ram_enable),
		.rtc_mode_i(rtc_mode), .ram_rdata_o(ram_rdata));

	cart_bus_ctrl u_bus_ctrl (.clk_sys, .reset, .dl_active_i, .bus_valid_i, .bus_write_i,
		.bus_addr_i, .rom_addr_i(rom_addr), .rom_ready_i, .rom_rvalid_i, .rom_rdata_i,
		.ram_rdata_i(ram_rdata), .bus_ready_o, .bus_rdata_o, .bus_rvalid_o,
		.reg_wr_en_o(reg_wr_en), .ram_wr_en_o(ram_wr_en), .rom_valid_o, .rom_addr_o);

endmodule

/* rtl/cart_pkg.sv */
package cart_pkg;

	// ------------------------------
	// mapper kinds
	// ------------------------------
	// decoded from the type byte of the header, everything unknown
	// falls back to a plain 32k rom
	typedef enum logic [2:0] {
		MBC_NONE,   // rom only, no banking
		MBC_1,
		MBC_2,      // 512 x 4 bit internal ram
		MBC_3,      // rtc capable
		MBC_5
	} mbc_kind_e;

	// ------------------------------
	// register write opcodes
	// ------------------------------
	// a write into rom space hits one of these, picked by addr[15:13]
	typedef enum logic [2:0] {
		OP_RAM_ENABLE = 3'b000, // 0000-1fff
		OP_ROM_BANK   = 3'b001, // 2000-3fff
		OP_RAM_BANK   = 3'b010, // 4000-5fff, also rtc select on mbc3
		OP_MODE       = 3'b011  // 6000-7fff, banking mode on mbc1
	} mbc_reg_op_e;

	// ------------------------------
	// cpu bus sequencer states
	// ------------------------------
	typedef enum logic [1:0] {
		ST_IDLE,     // ready for a new request
		ST_ROM_REQ,  // rom request presented, waiting for rom_ready
		ST_ROM_WAIT, // rom request taken, waiting for the data
		ST_RESP      // ram / open bus data on its way back
	} bus_state_e;

endpackage

/* rtl/cart_ram.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module cart_ram import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        ram_wr_en_i,  // accepted write into a000-bfff
	input  logic [`CART_RAM_ADDR_W-1:0] ram_addr_i,
	input  logic [`CART_ADDR_W-1:0]     bus_addr_i,
	input  logic [`CART_DATA_W-1:0]     bus_wdata_i,
	input  mbc_kind_e                   mbc_kind_i,
	input  logic                        ram_enable_i,
	input  logic                        rtc_mode_i,
	output logic [`CART_DATA_W-1:0]     ram_rdata_o
);

	logic [`CART_DATA_W-1:0] mem [`CART_RAM_SIZE];
	logic [`CART_DATA_W-1:0] rd_q;
	logic                    enable_q;
	logic                    rtc_q;
	logic                    nibble_q;     // mbc2 internal ram, 4 bits wide

	always_ff @(posedge clk_sys) begin
		if (ram_wr_en_i && ram_enable_i && !rtc_mode_i)
			mem[ram_addr_i] <= bus_wdata_i;
		rd_q     <= mem[ram_addr_i];
		// gating conditions sampled with the read, the cpu address moves on
		enable_q <= ram_enable_i;
		rtc_q    <= rtc_mode_i;
		nibble_q <= (mbc_kind_i == MBC_2) && (bus_addr_i[15:9] == 7'b1010000);
	end

	// read data gate
	always_comb begin
		if (!enable_q)
			ram_rdata_o = `CART_OPEN_BUS;               // ram closed
		else if (nibble_q)
			ram_rdata_o = {4'hF, rd_q[3:0]};            // a000-a1ff on mbc2
		else if (rtc_q)
			ram_rdata_o = '0;                           // no clock behind it
		else
			ram_rdata_o = rd_q;
	end

endmodule

/* rtl/mbc_map.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module mbc_map import cart_pkg::*; (
	input  logic [`CART_ADDR_W-1:0]     bus_addr_i,
	input  mbc_kind_e                   mbc_kind_i,
	input  logic [`CART_ROM_BANK_W-1:0] rom_mask_i,
	input  logic [`CART_RAM_BANK_W-1:0] ram_mask_i,
	input  logic [`CART_ROM_BANK_W-1:0] rom_bank_i,
	input  logic [`CART_RAM_BANK_W-1:0] ram_bank_i,
	input  logic                        mbc1_mode_i,
	output logic [`CART_ROM_ADDR_W-1:0] rom_addr_o,
	output logic [`CART_RAM_ADDR_W-1:0] ram_addr_o
);

	logic [`CART_ROM_BANK_W-1:0] rom_bank_sel;
	logic [`CART_RAM_BANK_W-1:0] ram_bank_sel;
	logic [6:0]                  mbc1_bank;    // ram bank bits on top of the 5 bit rom bank

	// upper two bits only count in mode 0
	assign mbc1_bank = {(mbc1_mode_i ? 2'b00 : ram_bank_i[1:0]), rom_bank_i[4:0]};

	// ------------------------------
	// rom bank
	// ------------------------------
	always_comb begin
		if (bus_addr_i[15:14] == 2'b00) begin
			rom_bank_sel = '0;                                // 0000-3fff fixed bank 0
		end else begin
			case (mbc_kind_i)
				MBC_1:        rom_bank_sel = {2'b00, mbc1_bank} & rom_mask_i;
				MBC_2, MBC_3: rom_bank_sel = {2'b00, rom_bank_i[6:0]} & rom_mask_i;
				MBC_5:        rom_bank_sel = rom_bank_i & rom_mask_i;       // 9 bits
				default:      rom_bank_sel = {8'd0, bus_addr_i[14]};       // flat 32k
			endcase
		end
	end

	assign rom_addr_o = {rom_bank_sel, bus_addr_i[`CART_ROM_OFS_W-1:0]};

	// ------------------------------
	// ram bank
	// ------------------------------
	always_comb begin
		case (mbc_kind_i)
			MBC_1: begin
				// banked only in 4/32 mode
				ram_bank_sel = {2'b00, (mbc1_mode_i ? ram_bank_i[1:0] : 2'b00) & ram_mask_i[1:0]};
			end
			MBC_3:   ram_bank_sel = {2'b00, ram_bank_i[1:0] & ram_mask_i[1:0]};
			MBC_5:   ram_bank_sel = ram_bank_i & ram_mask_i;
			default: ram_bank_sel = '0;                       // mbc2 and rom only
		endcase
	end

	assign ram_addr_o = {ram_bank_sel, bus_addr_i[`CART_RAM_OFS_W-1:0]};

endmodule

/* rtl/mbc_regs.sv */
`timescale 1ns/100ps

`include "cart_macros.svh"

module mbc_regs import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        dl_active_i,  // hold everything while loading
	input  logic                        reg_wr_en_i,  // accepted write into rom space
	input  logic [`CART_ADDR_W-1:0]     bus_addr_i,
	input  logic [`CART_DATA_W-1:0]     bus_wdata_i,
	input  mbc_kind_e                   mbc_kind_i,
	output logic [`CART_ROM_BANK_W-1:0] rom_bank_o,
	output logic [`CART_RAM_BANK_W-1:0] ram_bank_o,
	output logic                        mbc1_mode_o,  // 0 = 16/8 mode, 1 = 4/32 mode
	output logic                        rtc_mode_o,   // mbc3 has the clock mapped at a000
	output logic                        ram_enable_o
);

	mbc_reg_op_e reg_op;

	// which register the write goes to
	assign reg_op = mbc_reg_op_e'(bus_addr_i[15:13]);

	// ------------------------------
	// register file
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i) begin
			rom_bank_o   <= 9'd1;                 // bank 1 sits at 4000 after power up
			ram_bank_o   <= '0;
			mbc1_mode_o  <= 1'b0;
			rtc_mode_o   <= 1'b0;
			ram_enable_o <= 1'b0;
		end else if (reg_wr_en_i) begin
			case (reg_op)
				OP_RAM_ENABLE: begin
					// anything but the key closes ram again
					ram_enable_o <= (bus_wdata_i[3:0] == `CART_RAM_ENABLE_KEY);
				end

				OP_ROM_BANK: begin
					if (mbc_kind_i == MBC_5) begin
						if (bus_addr_i[12])
							rom_bank_o[8] <= bus_wdata_i[0];          // 3000-3fff high bit
						else
							rom_bank_o[7:0] <= bus_wdata_i;           // 2000-2fff low byte
					end else if (bus_wdata_i[6:0] == 7'd0) begin
						rom_bank_o <= 9'd1;                       // bank 0 can't be selected
					end else begin
						rom_bank_o <= {2'b00, bus_wdata_i[6:0]};
					end
				end

				OP_RAM_BANK: begin
					if (mbc_kind_i == MBC_3) begin
						if (bus_wdata_i[3]) begin
							rtc_mode_o <= 1'b1;                       // 08-0c pick a clock reg
						end else begin
							rtc_mode_o <= 1'b0;                       // back to ram
							ram_bank_o <= {2'b00, bus_wdata_i[1:0]};
						end
					end else if (mbc_kind_i == MBC_5) begin
						ram_bank_o <= bus_wdata_i[3:0];
					end else begin
						// mbc1 reuses these two bits as rom bank 6:5
						ram_bank_o <= {2'b00, bus_wdata_i[1:0]};
					end
				end

				OP_MODE: begin
					if (mbc_kind_i == MBC_1)
						mbc1_mode_o <= bus_wdata_i[0];
					// mbc3 latches its clock here, nothing to do without rtc
				end

				default: begin
					// a000+ never reaches this block
				end
			endcase
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cart mapper testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_cart_mapper -o tb_cart_mapper

./obj_dir/tb_cart_mapper | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
else
	exit 1
fi
